// File: cacheGeomPkg.sv
package cacheGeomPkg;

  // address split: tag | index | offset
  localparam int addrWidth = 32;
  localparam int wordWidth = 64;
  localparam int lineBytes = 32;
  localparam int numSets = 64;
  localparam int numWays = 2;
  localparam int indexBits = 6;
  localparam int offsetBits = 5;
  localparam int tagBits = addrWidth - indexBits - offsetBits;

  // doublewords per line and the offset bits that pick one
  localparam int wordsPerLine = (lineBytes * 8) / wordWidth;
  localparam int wordSelBits = $clog2(wordsPerLine);

  // miss sequence runs writeBack only for a dirty victim
  typedef enum logic [2:0] {
    idle,
    compare,
    writeBack,
    refillReq,
    refillData,
    install
  } ctrlState_t;

  // one line seen as doublewords for loads and bursts,
  // or as bytes for the masked store merge
  typedef union packed {
    logic [wordsPerLine-1:0][wordWidth-1:0] words;
    logic [lineBytes-1:0][7:0] bytes;
  } cacheLine_u;

endpackage

// File: memBusPkg.sv
package memBusPkg;

  // one doubleword per beat
  localparam int busWidth = 64;

  // a full line moves as one burst
  localparam int burstLen = 4;

  // counts beats within a burst
  localparam int beatCntBits = $clog2(burstLen);

endpackage

// File: dcacheCtrl.sv
module dcacheCtrl
  import cacheGeomPkg::*;
  import memBusPkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     reqValid_i,
  input  logic                     reqWrite_i,
  input  logic [addrWidth-1:0]     reqAddr_i,
  input  logic [wordWidth-1:0]     wrData_i,
  input  logic [wordWidth/8-1:0]   wrMask_i,
  input  logic [wordWidth-1:0]     hitWord_i,
  input  cacheLine_u               victimLine_i,
  input  cacheLine_u               fillLine_i,
  input  logic                     fillDone_i,
  input  logic                     memRdReady_i,
  input  logic                     memWrReady_i,
  output logic                     addrOk_o,
  output logic                     dataOk_o,
  output logic                     dataNotOk_o,
  output logic                     memRdValid_o,
  output logic [addrWidth-1:0]     memRdAddr_o,
  output logic                     memWrValid_o,
  output logic [addrWidth-1:0]     memWrAddr_o,
  output logic                     fillStart_o,
  output logic                     wbLoad_o,
  output logic                     wbAdvance_o,
  output logic [indexBits-1:0]     rdIndex_o,
  output logic [indexBits-1:0]     wrIndex_o,
  output logic                     wrWay_o,
  output logic                     wrEn_o,
  output cacheLine_u               wrLine_o,
  output logic [lineBytes-1:0]     wrByteEn_o,
  output logic [offsetBits-1:0]    selOffset_o
);

  ctrlState_t state, nextState;

  logic                   reqWrite;
  logic [addrWidth-1:0]   reqAddr;
  logic [wordWidth-1:0]   wrData;
  logic [wordWidth/8-1:0] wrMask;

  logic [tagBits-1:0]     reqTag;
  logic [indexBits-1:0]   reqIndex;
  logic [offsetBits-1:0]  reqOffset;
  logic [wordSelBits-1:0] reqSlot;

  logic [tagBits-1:0]     tagArr [numWays][numSets];
  logic [numSets-1:0]     validArr [numWays];
  logic [numSets-1:0]     dirtyArr [numWays];

  logic [numWays-1:0]     wayHit;
  logic                   hit;
  logic                   hitWay;
  logic                   accept;
  logic                   storeHit;
  logic                   victimPick;
  logic                   victimWay;
  logic                   needWb;
  logic [beatCntBits-1:0] wbCnt;
  logic [7:0]             victimLfsr;
  logic [wordWidth-1:0]   storeWord;

  assign reqTag    = reqAddr[addrWidth-1 -: tagBits];
  assign reqIndex  = reqAddr[offsetBits +: indexBits];
  assign reqOffset = reqAddr[offsetBits-1:0];
  assign reqSlot   = reqAddr[offsetBits-1 -: wordSelBits];

  // tag compare against both ways of the latched set
  always_comb begin
    for (int w = 0; w < numWays; w++) begin
      wayHit[w] = validArr[w][reqIndex] && (tagArr[w][reqIndex] == reqTag);
    end
  end

  assign hit      = |wayHit;
  assign hitWay   = wayHit[1];
  assign addrOk_o = (state == idle) || (state == compare && hit);
  assign accept   = reqValid_i && addrOk_o;
  assign dataOk_o = (state == compare) && hit;
  assign storeHit = dataOk_o && reqWrite;

  assign dataNotOk_o = (state == compare && !hit) || (state == writeBack) ||
                       (state == refillReq) || (state == refillData) || (state == install);

  // invalid way first, otherwise the lfsr decides
  assign victimPick = !validArr[0][reqIndex] ? 1'b0 :
                      !validArr[1][reqIndex] ? 1'b1 : victimLfsr[0];
  assign needWb = validArr[victimPick][reqIndex] && dirtyArr[victimPick][reqIndex];

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (accept) begin
          nextState = compare;
        end
      end
      compare: begin
        if (hit) begin
          nextState = accept ? compare : idle;
        end else begin
          nextState = needWb ? writeBack : refillReq;
        end
      end
      writeBack: begin
        if (memWrReady_i && wbCnt == beatCntBits'(burstLen - 1)) begin
          nextState = refillReq;
        end
      end
      refillReq: begin
        if (memRdReady_i) begin
          nextState = refillData;
        end
      end
      refillData: begin
        if (fillDone_i) begin
          nextState = install;
        end
      end
      install: begin
        nextState = compare;
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= idle;
      reqWrite   <= 1'b0;
      reqAddr    <= '0;
      victimWay  <= 1'b0;
      wbCnt      <= '0;
      victimLfsr <= 8'h5a;
    end else begin
      state <= nextState;
      // galois step, taps 8,6,5,4
      victimLfsr <= {1'b0, victimLfsr[7:1]} ^ (victimLfsr[0] ? 8'hb8 : 8'h00);
      if (accept) begin
        reqWrite <= reqWrite_i;
        reqAddr  <= reqAddr_i;
      end
      if (state == compare && !hit) begin
        victimWay <= victimPick;
        wbCnt     <= '0;
      end else if (wbAdvance_o) begin
        wbCnt <= wbCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wrData <= wrData_i;
      wrMask <= wrMask_i;
    end
    if (state == install) begin
      tagArr[victimWay][reqIndex] <= reqTag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '{default: '0};
      dirtyArr <= '{default: '0};
    end else if (state == install) begin
      validArr[victimWay][reqIndex] <= 1'b1;
      dirtyArr[victimWay][reqIndex] <= 1'b0;
    end else if (storeHit) begin
      dirtyArr[hitWay][reqIndex] <= 1'b1;
    end
  end

  // memory side
  assign memWrValid_o = (state == writeBack);
  assign memWrAddr_o  = {tagArr[victimWay][reqIndex], reqIndex, {offsetBits{1'b0}}};
  assign memRdValid_o = (state == refillReq);
  assign memRdAddr_o  = {reqTag, reqIndex, {offsetBits{1'b0}}};
  assign fillStart_o  = (state == refillReq);
  assign wbLoad_o     = (state == compare) && !hit && needWb;
  assign wbAdvance_o  = memWrValid_o && memWrReady_i;

  // data array side
  assign rdIndex_o   = accept ? reqAddr_i[offsetBits +: indexBits] : reqIndex;
  assign wrIndex_o   = reqIndex;
  assign wrWay_o     = (state == compare) ? (hit ? hitWay : victimPick) : victimWay;
  assign wrEn_o      = (state == install) || storeHit;
  assign selOffset_o = reqOffset;

  // store bytes over the current doubleword
  always_comb begin
    for (int b = 0; b < wordWidth / 8; b++) begin
      storeWord[b*8 +: 8] = wrMask[b] ? wrData[b*8 +: 8] : hitWord_i[b*8 +: 8];
    end
  end

  // on a miss the selected line passes unchanged to the writeback buffer
  always_comb begin
    wrLine_o   = victimLine_i;
    wrByteEn_o = '0;
    if (state == install) begin
      wrLine_o   = fillLine_i;
      wrByteEn_o = '1;
    end else if (storeHit) begin
      wrLine_o.words[reqSlot] = storeWord;
      wrByteEn_o[reqSlot*(wordWidth/8) +: wordWidth/8] = '1;
    end
  end

endmodule

// File: refillBuffer.sv
module refillBuffer
  import cacheGeomPkg::*;
  import memBusPkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fillStart_i,
  input  logic [busWidth-1:0] memRdData_i,
  input  logic                memRdDataValid_i,
  input  logic                memRdLast_i,
  input  logic                wbLoad_i,
  input  cacheLine_u          victimLine_i,
  input  logic                wbAdvance_i,
  output cacheLine_u          fillLine_o,
  output logic                fillDone_o,
  output logic [busWidth-1:0] memWrData_o
);

  logic [beatCntBits-1:0] fillCnt;
  logic                   fillDone;
  cacheLine_u             fillLine;
  cacheLine_u             wbLine;

  // refill beat position, restarted for every refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fillCnt  <= '0;
      fillDone <= 1'b0;
    end else begin
      fillDone <= memRdDataValid_i && memRdLast_i;
      if (fillStart_i) begin
        fillCnt <= '0;
      end else if (memRdDataValid_i) begin
        fillCnt <= fillCnt + 1'b1;
      end
    end
  end

  // beats arrive in ascending address order
  always_ff @(posedge clk) begin
    if (memRdDataValid_i) begin
      fillLine.words[fillCnt] <= memRdData_i;
    end
  end

  // victim shifts down one doubleword per accepted write beat
  always_ff @(posedge clk) begin
    if (wbLoad_i) begin
      wbLine <= victimLine_i;
    end else if (wbAdvance_i) begin
      wbLine <= wbLine >> busWidth;
    end
  end

  assign fillLine_o  = fillLine;
  assign fillDone_o  = fillDone;
  assign memWrData_o = wbLine.words[0];

endmodule

// File: dcacheDataArray.sv
module dcacheDataArray
  import cacheGeomPkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [indexBits-1:0]  rdIndex_i,
  input  logic [indexBits-1:0]  wrIndex_i,
  input  logic                  wrWay_i,
  input  logic                  wrEn_i,
  input  cacheLine_u            wrLine_i,
  input  logic [lineBytes-1:0]  wrByteEn_i,
  input  logic [offsetBits-1:0] selOffset_i,
  input  logic                  hitWay_i,
  output cacheLine_u            way0Line_o,
  output cacheLine_u            way1Line_o,
  output logic [wordWidth-1:0]  hitWord_o
);

  cacheLine_u mem [numWays][numSets];
  cacheLine_u rdLine [numWays];
  cacheLine_u mergedLine;

  // byte merge of the written line
  always_comb begin
    mergedLine = mem[wrWay_i][wrIndex_i];
    for (int b = 0; b < lineBytes; b++) begin
      if (wrByteEn_i[b]) begin
        mergedLine.bytes[b] = wrLine_i.bytes[b];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      mem[wrWay_i][wrIndex_i] <= mergedLine;
    end
  end

  // registered read of both ways
  // a write to the set being read is forwarded so back-to-back hits see it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdLine <= '{default: '0};
    end else begin
      for (int w = 0; w < numWays; w++) begin
        if (wrEn_i && wrWay_i == 1'(w) && wrIndex_i == rdIndex_i) begin
          rdLine[w] <= mergedLine;
        end else begin
          rdLine[w] <= mem[w][rdIndex_i];
        end
      end
    end
  end

  assign way0Line_o = rdLine[0];
  assign way1Line_o = rdLine[1];

  // doubleword at the request offset in the hitting way
  assign hitWord_o = rdLine[hitWay_i].words[selOffset_i[offsetBits-1 -: wordSelBits]];

endmodule

// File: dcacheTop.sv
module dcacheTop
  import cacheGeomPkg::*;
  import memBusPkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   reqValid_i,
  input  logic                   reqWrite_i,
  input  logic [addrWidth-1:0]   reqAddr_i,
  input  logic [wordWidth-1:0]   wrData_i,
  input  logic [wordWidth/8-1:0] wrMask_i,
  output logic                   addrOk_o,
  output logic                   dataOk_o,
  output logic                   dataNotOk_o,
  output logic [wordWidth-1:0]   rdData_o,
  output logic                   memRdValid_o,
  output logic [addrWidth-1:0]   memRdAddr_o,
  input  logic                   memRdReady_i,
  input  logic [busWidth-1:0]    memRdData_i,
  input  logic                   memRdDataValid_i,
  input  logic                   memRdLast_i,
  output logic                   memWrValid_o,
  output logic [addrWidth-1:0]   memWrAddr_o,
  input  logic                   memWrReady_i,
  output logic [busWidth-1:0]    memWrData_o
);

  cacheLine_u           fillLine;
  cacheLine_u           wrLine;
  cacheLine_u           way0Line;
  cacheLine_u           way1Line;
  cacheLine_u           victimLine;
  logic                 fillDone;
  logic                 fillStart;
  logic                 wbLoad;
  logic                 wbAdvance;
  logic [indexBits-1:0] rdIndex;
  logic [indexBits-1:0] wrIndex;
  logic                 wrWay;
  logic                 wrEn;
  logic [lineBytes-1:0] wrByteEn;
  logic [offsetBits-1:0] selOffset;

  // line of the way the controller points at, hit way or victim
  assign victimLine = wrWay ? way1Line : way0Line;

  dcacheCtrl ctrl0 (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid_i), .reqWrite_i(reqWrite_i), .reqAddr_i(reqAddr_i),
    .wrData_i(wrData_i), .wrMask_i(wrMask_i), .hitWord_i(rdData_o),
    .victimLine_i(victimLine), .fillLine_i(fillLine), .fillDone_i(fillDone),
    .memRdReady_i(memRdReady_i), .memWrReady_i(memWrReady_i),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .dataNotOk_o(dataNotOk_o),
    .memRdValid_o(memRdValid_o), .memRdAddr_o(memRdAddr_o),
    .memWrValid_o(memWrValid_o), .memWrAddr_o(memWrAddr_o),
    .fillStart_o(fillStart), .wbLoad_o(wbLoad), .wbAdvance_o(wbAdvance),
    .rdIndex_o(rdIndex), .wrIndex_o(wrIndex), .wrWay_o(wrWay), .wrEn_o(wrEn),
    .wrLine_o(wrLine), .wrByteEn_o(wrByteEn), .selOffset_o(selOffset)
  );

  // writeback buffer loads the unmodified victim from the controller
  refillBuffer refill0 (
    .clk(clk), .rst_n(rst_n), .fillStart_i(fillStart),
    .memRdData_i(memRdData_i), .memRdDataValid_i(memRdDataValid_i),
    .memRdLast_i(memRdLast_i), .wbLoad_i(wbLoad), .victimLine_i(wrLine),
    .wbAdvance_i(wbAdvance), .fillLine_o(fillLine), .fillDone_o(fillDone),
    .memWrData_o(memWrData_o)
  );

  dcacheDataArray data0 (
    .clk(clk), .rst_n(rst_n), .rdIndex_i(rdIndex), .wrIndex_i(wrIndex),
    .wrWay_i(wrWay), .wrEn_i(wrEn), .wrLine_i(wrLine), .wrByteEn_i(wrByteEn),
    .selOffset_i(selOffset), .hitWay_i(wrWay),
    .way0Line_o(way0Line), .way1Line_o(way1Line), .hitWord_o(rdData_o)
  );

endmodule

// File: dcache_chk.sv
module dcache_chk
  import cacheGeomPkg::*;
(
  input logic                 clk,
  input logic                 rst_n,
  input logic                 memRdValid_o,
  input logic [addrWidth-1:0] memRdAddr_o,
  input logic                 memRdReady_i,
  input logic                 memWrValid_o,
  input logic [addrWidth-1:0] memWrAddr_o,
  input logic                 memWrReady_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // read request holds until the memory takes it
  rdHold: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_o && !memRdReady_i |=> memRdValid_o && $stable(memRdAddr_o))
    else $error("read request dropped or address changed under back-pressure");

  // writeback holds its address while stalled
  wrHold: assert property (@(posedge clk) disable iff (!rst_n)
    memWrValid_o && !memWrReady_i |=> memWrValid_o && $stable(memWrAddr_o))
    else $error("write request dropped or address changed under back-pressure");

endmodule

// File: tb_dcache.sv
module tb_dcache;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod = 8;
  localparam int numOps = 400;
  localparam int missCycles = 200;
  localparam logic [31:0] seed = 32'h91ec;
  localparam logic [20:0] tagBase = 21'h0a5f1;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic reqValid_i, reqWrite_i;
  logic [31:0] reqAddr_i;
  logic [63:0] wrData_i;
  logic [7:0] wrMask_i;
  logic addrOk_o, dataOk_o, dataNotOk_o;
  logic [63:0] rdData_o;
  logic memRdValid_o, memRdReady_i, memRdDataValid_i, memRdLast_i;
  logic [31:0] memRdAddr_o, memWrAddr_o;
  logic [63:0] memRdData_i, memWrData_o;
  logic memWrValid_o, memWrReady_i;

  logic [31:0] lfsr = seed;
  logic [63:0] mainMem [logic [31:0]];
  logic [63:0] refMem [logic [31:0]];
  logic dirtyLines [logic [31:0]];
  int dataErrs = 0;
  int protoErrs = 0;
  int wbBeat = 0;
  logic prevRdStall = 1'b0;
  logic prevWrStall = 1'b0;
  logic [31:0] prevRdAddr, prevWrAddr;

  always #(clkPeriod / 2) clk = ~clk;

  dcacheTop dut0 (.*);

  bind dcacheTop dcache_chk chk0 (
    .clk(clk), .rst_n(rst_n), .memRdValid_o(memRdValid_o), .memRdAddr_o(memRdAddr_o),
    .memRdReady_i(memRdReady_i), .memWrValid_o(memWrValid_o),
    .memWrAddr_o(memWrAddr_o), .memWrReady_i(memWrReady_i)
  );

  // galois lfsr, one step per bit
  function logic stepBit();
    logic b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'ha300_0000 : 32'h0);
    return b;
  endfunction

  function logic [63:0] randBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], stepBit()};
    end
    return v;
  endfunction

  // power-on contents, unique per doubleword address
  function logic [63:0] initWord(input logic [31:0] a);
    return {a ^ 32'h5a3c_96e1, ~a + 32'h0001_9e37};
  endfunction

  function logic [63:0] memWord(input logic [31:0] a);
    return mainMem.exists(a) ? mainMem[a] : initWord(a);
  endfunction

  function logic [63:0] refWord(input logic [31:0] a);
    return refMem.exists(a) ? refMem[a] : initWord(a);
  endfunction

  function void applyStore(input logic [31:0] a, input logic [63:0] d, input logic [7:0] m);
    logic [63:0] w;
    w = refWord(a);
    for (int b = 0; b < 8; b++) begin
      if (m[b]) begin
        w[b*8 +: 8] = d[b*8 +: 8];
      end
    end
    refMem[a] = w;
    dirtyLines[{a[31:5], 5'b0}] = 1'b1;
  endfunction

  // one request, accepted then completed, leaves us just after a rising edge
  task automatic doAccess(input logic wr, input logic [31:0] a, input logic [63:0] d,
                          input logic [7:0] m, input logic repeatLoad);
    int latency;
    logic sawMiss;
    latency = 0;
    sawMiss = 1'b0;
    reqValid_i = 1'b1;
    reqWrite_i = wr;
    reqAddr_i = a;
    wrData_i = d;
    wrMask_i = m;
    forever begin
      @(negedge clk);
      if (addrOk_o) break;
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    reqValid_i = 1'b0;
    forever begin
      @(negedge clk);
      latency++;
      if (dataNotOk_o) sawMiss = 1'b1;
      if (dataOk_o) break;
    end
    if (!wr && rdData_o !== refWord(a)) begin
      $display("ERR %0t: load %h got %h expected %h", $time, a, rdData_o, refWord(a));
      dataErrs++;
    end
    if (repeatLoad && (latency != 1 || sawMiss)) begin
      $display("ERR %0t: repeated load %h took %0d cycles, miss %0b", $time, a, latency,
               sawMiss);
      dataErrs++;
    end
    if (wr) applyStore(a, d, m);
    @(posedge clk);
    #1;
  endtask

  // refill side of the memory model
  initial begin
    logic [31:0] lineAddr;
    int lat;
    wait (rst_n);
    forever begin
      @(posedge clk);
      #1;
      memRdReady_i = |randBits(2);
      @(negedge clk);
      if (memRdValid_o && memRdReady_i) begin
        lineAddr = memRdAddr_o;
        if (wbBeat != 0) begin
          $display("refill of %h requested before the writeback finished", lineAddr);
          protoErrs++;
        end
        @(posedge clk);
        #1;
        memRdReady_i = 1'b0;
        lat = int'(randBits(2));
        repeat (lat) begin
          @(posedge clk);
          #1;
        end
        for (int b = 0; b < 4; b++) begin
          memRdDataValid_i = 1'b1;
          memRdLast_i = (b == 3);
          memRdData_i = memWord(lineAddr + 32'(b * 8));
          @(posedge clk);
          #1;
        end
        memRdDataValid_i = 1'b0;
        memRdLast_i = 1'b0;
      end
    end
  end

  // writeback side, beats checked against the reference
  initial begin
    logic [31:0] beatAddr;
    wait (rst_n);
    forever begin
      @(posedge clk);
      #1;
      memWrReady_i = |randBits(2);
      @(negedge clk);
      if (memWrValid_o && memWrReady_i) begin
        beatAddr = memWrAddr_o + 32'(wbBeat * 8);
        if (wbBeat == 0) begin
          if (!dirtyLines.exists(memWrAddr_o)) begin
            $display("writeback of line %h that was never stored to", memWrAddr_o);
            protoErrs++;
          end
          dirtyLines.delete(memWrAddr_o);
        end
        if (memWrData_o !== refWord(beatAddr)) begin
          $display("ERR %0t: writeback %h got %h expected %h", $time, beatAddr,
                   memWrData_o, refWord(beatAddr));
          dataErrs++;
        end
        mainMem[beatAddr] = memWrData_o;
        wbBeat = (wbBeat + 1) % 4;
      end
    end
  end

  // back-pressure monitor
  always @(negedge clk) begin
    if (rst_n) begin
      if ((memRdValid_o || memWrValid_o) && addrOk_o) begin
        $display("addrOk_o high at %0t while a memory request is open", $time);
        protoErrs++;
      end
      if (prevRdStall && (!memRdValid_o || memRdAddr_o !== prevRdAddr)) begin
        $display("read request not held under back-pressure at %0t", $time);
        protoErrs++;
      end
      if (prevWrStall && (!memWrValid_o || memWrAddr_o !== prevWrAddr)) begin
        $display("write request not held under back-pressure at %0t", $time);
        protoErrs++;
      end
      prevRdStall = memRdValid_o && !memRdReady_i;
      prevWrStall = memWrValid_o && !memWrReady_i;
      prevRdAddr = memRdAddr_o;
      prevWrAddr = memWrAddr_o;
    end
  end

  initial begin
    #(numOps * missCycles * clkPeriod);
    $display("timeout: run did not finish within %0d operations worth of misses", numOps);
    $display("sim failed");
    $finish;
  end

  initial begin
    logic wr;
    logic rep;
    logic haveLast;
    logic [31:0] addr;
    logic [31:0] lastAddr;
    logic [63:0] d;
    logic [7:0] m;
    haveLast = 1'b0;
    lastAddr = '0;
    reqValid_i = 1'b0;
    reqWrite_i = 1'b0;
    reqAddr_i = '0;
    wrData_i = '0;
    wrMask_i = '0;
    memRdReady_i = 1'b0;
    memRdData_i = '0;
    memRdDataValid_i = 1'b0;
    memRdLast_i = 1'b0;
    memWrReady_i = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (!addrOk_o || dataOk_o || dataNotOk_o || memRdValid_o || memWrValid_o) begin
      $display("ERR %0t: wrong outputs after reset", $time);
      dataErrs++;
    end
    @(posedge clk);
    #1;
    for (int op = 0; op < numOps; op++) begin
      rep = haveLast && (randBits(2) == 0);
      // two sets, four tags each, so ways keep getting evicted
      addr = {tagBase + 21'(randBits(2)), randBits(1) ? 6'd17 : 6'd3, 2'(randBits(2)), 3'b0};
      wr = randBits(1);
      d = randBits(64);
      m = randBits(8);
      if (rep) begin
        addr = lastAddr;
        wr = 1'b0;
      end
      doAccess(wr, addr, d, m, rep);
      lastAddr = addr;
      haveLast = 1'b1;
      if (randBits(2) == 0) begin
        @(posedge clk);
        #1;
      end
    end
    repeat (4) @(posedge clk);
    $display("errors: %0d data, %0d protocol", dataErrs, protoErrs);
    if (dataErrs == 0 && protoErrs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: build.f
cacheGeomPkg.sv
memBusPkg.sv
dcacheCtrl.sv
refillBuffer.sv
dcacheDataArray.sv
dcacheTop.sv
dcache_chk.sv
tb_dcache.sv

// File: Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FLIST) --Mdir $(OBJ_DIR) -o V$*

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
